// File: src/isaPkg.sv
package isaPkg;

    // Datapath and register file sizes
    localparam int wordW = 16;
    localparam int regAddrW = 3;
    localparam int numRegs = 8;
    localparam int opcodeW = 5;
    localparam int fnW = 2;

    // Lsb of each instruction field
    localparam int opLsb = 11;
    localparam int rsLsb = 8;
    localparam int rtLsb = 5;
    localparam int rdAluLsb = 2;
    localparam int rdImmLsb = 5;
    localparam int fnLsb = 0;

    // Immediate widths
    localparam int immShortW = 5;
    localparam int immLongW = 8;

    // Instructions are two bytes apart
    localparam logic [wordW-1:0] pcStep = 16'd2;

    typedef enum logic [opcodeW-1:0] {
        opHalt  = 5'b00000,
        opNop   = 5'b00001,
        opAddi  = 5'b01000,
        opSubi  = 5'b01001,
        opXori  = 5'b01010,
        opAndni = 5'b01011,
        opBeqz  = 5'b01100,
        opBnez  = 5'b01101,
        opLbi   = 5'b11000,
        opAlu   = 5'b11011
    } opcodeT;

    // Function field of the register-register form
    typedef enum logic [fnW-1:0] {
        fnAdd  = 2'b00,
        fnSub  = 2'b01,
        fnXor  = 2'b10,
        fnAndn = 2'b11
    } aluFnT;

    // Execute operation on A and on rt or the immediate as B
    typedef enum logic [2:0] {
        aluAdd,
        aluSubRev,
        aluXor,
        aluAndn,
        aluPassB
    } aluOpT;

endpackage

// File: src/pipePkg.sv
package pipePkg;

    import isaPkg::*;

    // Fetch to decode
    typedef struct packed {
        logic             valid;
        logic [wordW-1:0] nextPc;
        logic [wordW-1:0] instr;
    } ifIdT;

    // Decode to execute
    typedef struct packed {
        logic                valid;
        aluOpT               aluOp;
        logic [wordW-1:0]    opA;
        logic [wordW-1:0]    opB;
        logic [wordW-1:0]    imm;
        logic                useImm;
        logic                writeEn;
        logic [regAddrW-1:0] dest;
        logic [regAddrW-1:0] rs;
        logic                rsValid;
        logic [regAddrW-1:0] rt;
        logic                rtValid;
        logic                isBranch;
        logic                branchOnZero;
        logic                isHalt;
        logic                illegal;
        logic [wordW-1:0]    nextPc;
    } idExT;

    // Execute to writeback
    typedef struct packed {
        logic                valid;
        logic                writeEn;
        logic [regAddrW-1:0] dest;
        logic [wordW-1:0]    result;
    } exWbT;

    // Taken branch back to the front end
    typedef struct packed {
        logic             take;
        logic [wordW-1:0] target;
    } redirectT;

endpackage

// File: src/fetch.sv
module fetch
    import isaPkg::*;
    import pipePkg::*;
(
    input  logic             clk,
    input  logic             arstN,
    input  logic [wordW-1:0] instr,
    input  redirectT         redirect,
    input  logic             halted,
    output logic [wordW-1:0] pc,
    output ifIdT             ifId
);

    logic [wordW-1:0] pcPlus;
    logic [wordW-1:0] pcNext;

    assign pcPlus = pc + pcStep;

    // Redirect wins over the halt freeze
    always_comb begin
        if (redirect.take) begin
            pcNext = redirect.target;
        end else if (halted) begin
            pcNext = pc;
        end else begin
            pcNext = pcPlus;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= '0;
        end else begin
            pc <= pcNext;
        end
    end

    // Word fetched this cycle is dropped on a redirect or once halted
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            ifId <= '0;
        end else begin
            ifId.valid  <= !redirect.take && !halted;
            ifId.nextPc <= pcPlus;
            ifId.instr  <= instr;
        end
    end

endmodule

// File: src/instrDecode.sv
module instrDecode
    import isaPkg::*;
    import pipePkg::*;
(
    input  logic             clk,
    input  logic             arstN,
    input  ifIdT             ifId,
    input  logic [wordW-1:0] rdData1,
    input  logic [wordW-1:0] rdData2,
    input  redirectT         redirect,
    output idExT             idEx
);

    opcodeT              op;
    aluFnT               fn;
    logic [regAddrW-1:0] rsIdx;
    logic [wordW-1:0]    immShort;
    logic [wordW-1:0]    immLong;
    idExT                dec;

    assign op    = opcodeT'(ifId.instr[opLsb +: opcodeW]);
    assign fn    = aluFnT'(ifId.instr[fnLsb +: fnW]);
    assign rsIdx = ifId.instr[rsLsb +: regAddrW];

    // Sign extended immediates
    assign immShort = {{(wordW-immShortW){ifId.instr[immShortW-1]}},
                       ifId.instr[immShortW-1:0]};
    assign immLong  = {{(wordW-immLongW){ifId.instr[immLongW-1]}},
                       ifId.instr[immLongW-1:0]};

    always_comb begin
        dec = '0;
        // The younger of a taken branch never reaches execute
        dec.valid  = ifId.valid && !redirect.take;
        dec.aluOp  = aluAdd;
        dec.opA    = rdData1;
        dec.opB    = rdData2;
        dec.rs     = rsIdx;
        dec.rt     = ifId.instr[rtLsb +: regAddrW];
        dec.nextPc = ifId.nextPc;

        case (op)
            opHalt: begin
                dec.isHalt = 1'b1;
            end
            opNop: ;
            opAddi, opSubi, opXori, opAndni: begin
                dec.useImm  = 1'b1;
                dec.imm     = immShort;
                dec.writeEn = 1'b1;
                dec.dest    = ifId.instr[rdImmLsb +: regAddrW];
                dec.rsValid = 1'b1;
                case (op)
                    opSubi:  dec.aluOp = aluSubRev;
                    opXori:  dec.aluOp = aluXor;
                    opAndni: dec.aluOp = aluAndn;
                    default: dec.aluOp = aluAdd;
                endcase
            end
            opBeqz, opBnez: begin
                dec.imm          = immLong;
                dec.rsValid      = 1'b1;
                dec.isBranch     = 1'b1;
                dec.branchOnZero = (op == opBeqz);
            end
            opLbi: begin
                // rs field names the destination here
                dec.aluOp   = aluPassB;
                dec.useImm  = 1'b1;
                dec.imm     = immLong;
                dec.writeEn = 1'b1;
                dec.dest    = rsIdx;
            end
            opAlu: begin
                dec.writeEn = 1'b1;
                dec.dest    = ifId.instr[rdAluLsb +: regAddrW];
                dec.rsValid = 1'b1;
                dec.rtValid = 1'b1;
                case (fn)
                    fnSub:   dec.aluOp = aluSubRev;
                    fnXor:   dec.aluOp = aluXor;
                    fnAndn:  dec.aluOp = aluAndn;
                    default: dec.aluOp = aluAdd;
                endcase
            end
            default: begin
                dec.illegal = 1'b1;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            idEx <= '0;
        end else begin
            idEx <= dec;
        end
    end

endmodule

// File: src/regFile.sv
module regFile
    import isaPkg::*;
    import pipePkg::*;
(
    input  logic                clk,
    input  logic                arstN,
    input  logic [regAddrW-1:0] rdAddr1,
    input  logic [regAddrW-1:0] rdAddr2,
    output logic [wordW-1:0]    rdData1,
    output logic [wordW-1:0]    rdData2,
    input  exWbT                wb
);

    logic [wordW-1:0] regs [numRegs];
    logic             wrEn;

    assign wrEn = wb.valid && wb.writeEn;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[wb.dest] <= wb.result;
        end
    end

    // Same cycle write shows through on both read ports
    assign rdData1 = (wrEn && wb.dest == rdAddr1) ? wb.result : regs[rdAddr1];
    assign rdData2 = (wrEn && wb.dest == rdAddr2) ? wb.result : regs[rdAddr2];

endmodule

// File: src/execute.sv
module execute
    import isaPkg::*;
    import pipePkg::*;
(
    input  logic     clk,
    input  logic     arstN,
    input  idExT     idEx,
    output exWbT     exWb,
    output redirectT redirect,
    output logic     halted,
    output logic     err
);

    logic             wbWrites;
    logic             fwdA;
    logic             fwdB;
    logic [wordW-1:0] opA;
    logic [wordW-1:0] opB;
    logic [wordW-1:0] aluB;
    logic [wordW-1:0] aluRes;
    logic             live;
    logic             stop;
    logic             isZero;
    logic             taken;
    logic             haltQ;
    logic             errQ;

    // Forward from the writeback register
    assign wbWrites = exWb.valid && exWb.writeEn;
    assign fwdA     = idEx.rsValid && wbWrites && (exWb.dest == idEx.rs);
    assign fwdB     = idEx.rtValid && wbWrites && (exWb.dest == idEx.rt);

    assign opA  = fwdA ? exWb.result : idEx.opA;
    assign opB  = fwdB ? exWb.result : idEx.opB;
    assign aluB = idEx.useImm ? idEx.imm : opB;

    always_comb begin
        case (idEx.aluOp)
            aluAdd:    aluRes = opA + aluB;
            aluSubRev: aluRes = aluB - opA;
            aluXor:    aluRes = opA ^ aluB;
            aluAndn:   aluRes = opA & ~aluB;
            aluPassB:  aluRes = aluB;
            default:   aluRes = '0;
        endcase
    end

    // Nothing past a halt or illegal instruction takes effect
    assign live = idEx.valid && !haltQ;
    assign stop = live && (idEx.isHalt || idEx.illegal);

    // Branch on operand one being zero or nonzero
    assign isZero = (opA == '0);
    assign taken  = live && idEx.isBranch && (isZero == idEx.branchOnZero);

    assign redirect.take   = taken;
    assign redirect.target = idEx.nextPc + idEx.imm;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            exWb <= '0;
        end else begin
            exWb.valid   <= live && !idEx.isHalt && !idEx.illegal;
            exWb.writeEn <= idEx.writeEn;
            exWb.dest    <= idEx.dest;
            exWb.result  <= aluRes;
        end
    end

    // Sticky until reset
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            haltQ <= 1'b0;
            errQ  <= 1'b0;
        end else begin
            if (stop) begin
                haltQ <= 1'b1;
            end
            if (live && idEx.illegal) begin
                errQ <= 1'b1;
            end
        end
    end

    assign halted = haltQ;
    assign err    = errQ;

endmodule

// File: src/proc.sv
module proc
    import isaPkg::*;
    import pipePkg::*;
(
    input  logic                clk,
    input  logic                arstN,
    input  logic [wordW-1:0]    instr,
    output logic [wordW-1:0]    pc,
    output logic                wbValid,
    output logic [regAddrW-1:0] wbReg,
    output logic [wordW-1:0]    wbData,
    output logic                halted,
    output logic                err
);

    ifIdT                ifId;
    idExT                idEx;
    exWbT                exWb;
    redirectT            redirect;
    logic [regAddrW-1:0] rdAddr1;
    logic [regAddrW-1:0] rdAddr2;
    logic [wordW-1:0]    rdData1;
    logic [wordW-1:0]    rdData2;

    // Register reads use the rs and rt fields of the decode instruction
    assign rdAddr1 = ifId.instr[rsLsb +: regAddrW];
    assign rdAddr2 = ifId.instr[rtLsb +: regAddrW];

    fetch fetch0 (.clk(clk), .arstN(arstN), .instr(instr), .redirect(redirect),
        .halted(halted), .pc(pc), .ifId(ifId));

    instrDecode decode0 (.clk(clk), .arstN(arstN), .ifId(ifId), .rdData1(rdData1),
        .rdData2(rdData2), .redirect(redirect), .idEx(idEx));

    regFile regFile0 (.clk(clk), .arstN(arstN), .rdAddr1(rdAddr1), .rdAddr2(rdAddr2),
        .rdData1(rdData1), .rdData2(rdData2), .wb(exWb));

    execute exec0 (.clk(clk), .arstN(arstN), .idEx(idEx), .exWb(exWb),
        .redirect(redirect), .halted(halted), .err(err));

    // Only register writes are reported
    assign wbValid = exWb.valid && exWb.writeEn;
    assign wbReg   = exWb.dest;
    assign wbData  = exWb.result;

endmodule

// File: test/procTb.sv
module procTb
    import isaPkg::*;
    import pipePkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    // One instruction word and the writeback it should produce
    typedef struct packed {
        logic [wordW-1:0]    word;
        logic                writes;
        logic [regAddrW-1:0] dest;
        logic [wordW-1:0]    data;
    } rowT;

    localparam int resetCycles = 16;
    localparam int holdCycles = 10;
    localparam logic [wordW-1:0] nopWord = {opNop, 11'd0};
    localparam logic [wordW-1:0] haltWord = {opHalt, 11'd0};
    localparam logic [wordW-1:0] badWord = 16'hF800;

    logic                clk;
    logic                arstN;
    logic [wordW-1:0]    instr;
    logic [wordW-1:0]    pc;
    logic                wbValid;
    logic [regAddrW-1:0] wbReg;
    logic [wordW-1:0]    wbData;
    logic                halted;
    logic                err;

    rowT  progRows[$];
    rowT  progA[$];
    rowT  progB[$];
    exWbT expected[$];
    int   cycleBudget = 0;

    proc DUT (
        .clk(clk), .arstN(arstN), .instr(instr), .pc(pc), .wbValid(wbValid),
        .wbReg(wbReg), .wbData(wbData), .halted(halted), .err(err)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    function automatic logic [wordW-1:0] encAlu(aluFnT fn, logic [regAddrW-1:0] rs,
        logic [regAddrW-1:0] rt, logic [regAddrW-1:0] rd);
        return {opAlu, rs, rt, rd, fn};
    endfunction

    function automatic logic [wordW-1:0] encImm(opcodeT op, logic [regAddrW-1:0] rs,
        logic [regAddrW-1:0] rd, logic [4:0] imm);
        return {op, rs, rd, imm};
    endfunction

    function automatic logic [wordW-1:0] encLong(opcodeT op, logic [regAddrW-1:0] rs,
        logic [7:0] imm);
        return {op, rs, imm};
    endfunction

    // Past the end of the table the port returns nops
    function automatic logic [wordW-1:0] fetchWord(logic [wordW-1:0] addr);
        int idx;
        idx = int'(addr >> 1);
        if (idx < progRows.size()) begin
            return progRows[idx].word;
        end
        return nopWord;
    endfunction

    task automatic addRow(input logic [wordW-1:0] word, input logic writes,
        input logic [regAddrW-1:0] dest, input logic [wordW-1:0] data);
        rowT row;
        row = '{word: word, writes: writes, dest: dest, data: data};
        progRows.push_back(row);
    endtask

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic checkReg(input string name, input logic [regAddrW-1:0] got,
        input logic [regAddrW-1:0] exp);
        if (got !== exp) begin
            abortRun($sformatf("Fail %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic checkData(input string name, input logic [wordW-1:0] got,
        input logic [wordW-1:0] exp);
        if (got !== exp) begin
            abortRun($sformatf("Fail %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic checkFlag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abortRun($sformatf("Fail %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic observeWb();
        exWbT want;
        if (wbValid) begin
            if (expected.size() == 0) begin
                abortRun($sformatf("Unexpected writeback to r%0d with value %h", wbReg, wbData));
            end else begin
                want = expected.pop_front();
                checkReg("wbReg", wbReg, want.dest);
                checkData("wbData", wbData, want.result);
            end
        end
    endtask

    // Dependent ALU chain, immediates, branches, then halt
    task automatic buildAluBranchProgram();
        addRow(encLong(opLbi, 3'd1, 8'h05), 1'b1, 3'd1, 16'h0005);
        addRow(encLong(opLbi, 3'd2, 8'hF0), 1'b1, 3'd2, 16'hFFF0);
        addRow(encAlu(fnAdd, 3'd1, 3'd2, 3'd3), 1'b1, 3'd3, 16'hFFF5);
        addRow(encAlu(fnSub, 3'd1, 3'd3, 3'd4), 1'b1, 3'd4, 16'hFFF0);
        addRow(encAlu(fnXor, 3'd4, 3'd3, 3'd5), 1'b1, 3'd5, 16'h0005);
        addRow(encAlu(fnAndn, 3'd3, 3'd5, 3'd6), 1'b1, 3'd6, 16'hFFF0);
        addRow(encImm(opAddi, 3'd6, 3'd7, 5'b11101), 1'b1, 3'd7, 16'hFFED);
        addRow(encImm(opSubi, 3'd1, 3'd2, 5'b00111), 1'b1, 3'd2, 16'h0002);
        addRow(encImm(opXori, 3'd2, 3'd3, 5'b11111), 1'b1, 3'd3, 16'hFFFD);
        addRow(encImm(opAndni, 3'd3, 3'd4, 5'b01111), 1'b1, 3'd4, 16'hFFF0);
        // Taken to pc 26 past the next two
        addRow(encLong(opBeqz, 3'd0, 8'd4), 1'b0, 3'd0, 16'h0000);
        addRow(encLong(opLbi, 3'd5, 8'h11), 1'b0, 3'd0, 16'h0000);
        addRow(encLong(opLbi, 3'd6, 8'h22), 1'b0, 3'd0, 16'h0000);
        addRow(encLong(opBnez, 3'd0, 8'd4), 1'b0, 3'd0, 16'h0000);
        addRow(encLong(opLbi, 3'd0, 8'h33), 1'b1, 3'd0, 16'h0033);
        // Taken to pc 36 only when r0 comes by forwarding
        addRow(encLong(opBnez, 3'd0, 8'd4), 1'b0, 3'd0, 16'h0000);
        addRow(encLong(opLbi, 3'd6, 8'h44), 1'b0, 3'd0, 16'h0000);
        addRow(encLong(opLbi, 3'd7, 8'h55), 1'b0, 3'd0, 16'h0000);
        addRow(encLong(opBeqz, 3'd0, 8'hFC), 1'b0, 3'd0, 16'h0000);
        addRow(encImm(opAddi, 3'd0, 3'd6, 5'b00001), 1'b1, 3'd6, 16'h0034);
        addRow(encAlu(fnAdd, 3'd6, 3'd6, 3'd7), 1'b1, 3'd7, 16'h0068);
        addRow(haltWord, 1'b0, 3'd0, 16'h0000);
        addRow(encLong(opLbi, 3'd1, 8'h77), 1'b0, 3'd0, 16'h0000);
    endtask

    task automatic buildIllegalProgram();
        addRow(encLong(opLbi, 3'd1, 8'h7F), 1'b1, 3'd1, 16'h007F);
        addRow(encImm(opAddi, 3'd1, 3'd2, 5'b00001), 1'b1, 3'd2, 16'h0080);
        addRow(badWord, 1'b0, 3'd0, 16'h0000);
        addRow(encLong(opLbi, 3'd3, 8'h01), 1'b0, 3'd0, 16'h0000);
        addRow(encLong(opLbi, 3'd4, 8'h02), 1'b0, 3'd0, 16'h0000);
    endtask

    task automatic runProgram(input string name, input logic expErr);
        exWbT             entry;
        logic [wordW-1:0] heldPc;
        expected.delete();
        foreach (progRows[i]) begin
            if (progRows[i].writes) begin
                entry = '{valid: 1'b1, writeEn: 1'b1, dest: progRows[i].dest,
                          result: progRows[i].data};
                expected.push_back(entry);
            end
        end
        @(posedge clk);
        arstN <= 1'b0;
        instr <= fetchWord('0);
        repeat (resetCycles) @(posedge clk);
        arstN <= 1'b1;
        do begin
            @(negedge clk);
            observeWb();
        end while (!halted);
        // Frozen front end and silent writeback once stopped
        heldPc = pc;
        repeat (holdCycles) begin
            @(negedge clk);
            observeWb();
            checkData("pc", pc, heldPc);
        end
        if (expected.size() != 0) begin
            abortRun($sformatf("%s stopped with %0d writebacks missing", name, expected.size()));
        end
        checkFlag("halted", halted, 1'b1);
        checkFlag("err", err, expErr);
    endtask

    // Instruction port answers the new pc in the same time step
    initial begin
        forever begin
            @(pc);
            instr <= fetchWord(pc);
        end
    end

    initial begin
        wait (cycleBudget > 0);
        repeat (cycleBudget) @(posedge clk);
        abortRun($sformatf("Timeout after %0d cycles without finishing", cycleBudget));
    end

    initial begin
        arstN = 1'b0;
        instr = '0;
        buildAluBranchProgram();
        progA = progRows;
        progRows.delete();
        buildIllegalProgram();
        progB = progRows;
        cycleBudget = (progA.size() + progB.size()) * 20 + 2 * (resetCycles + holdCycles);
        progRows = progA;
        runProgram("ALU and branch program", 1'b0);
        progRows = progB;
        runProgram("Illegal opcode program", 1'b1);
        $display("TEST PASSED");
        $finish;
    end

endmodule

// File: proc.f
src/isaPkg.sv
src/pipePkg.sv
src/fetch.sv
src/instrDecode.sv
src/regFile.sv
src/execute.sv
src/proc.sv
test/procTb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --timescale 1ns/1ps
TOP      = procTb
FILELIST = proc.f
OBJDIR   = obj_dir

.PHONY: simulate clean

simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -q "TEST PASSED"

clean:
	rm -rf $(OBJDIR)
